/* rv_ex_pkg.sv */
// rv32i execute stage shared widths, encodings and pipeline bundles
`default_nettype none

package rv_ex_pkg;

  localparam int xlen      = 32;                  // data and address width
  localparam int shamt_w   = 5;                   // shift amount, low bits of operand b
  localparam int reg_idx_w = 5;                   // x0..x31
  localparam int mask_w    = 4;                   // one lane per byte of a word

  localparam logic [xlen-1:0] pc_step = 4;        // instruction size in bytes

  // access size from funct3[1:0] of loads and stores
  localparam logic [1:0] sz_byte = 2'b00;
  localparam logic [1:0] sz_half = 2'b01;
  localparam logic [1:0] sz_word = 2'b10;

  // unshifted lane patterns per access size
  localparam logic [mask_w-1:0] lane_byte = 4'b0001;
  localparam logic [mask_w-1:0] lane_half = 4'b0011;
  localparam logic [mask_w-1:0] lane_word = 4'b1111;

  typedef enum logic [2:0] {
    class_mem    = 3'd0,                          // loads and stores
    class_branch = 3'd1,
    class_reg    = 3'd2,                          // r-type
    class_imm    = 3'd3,                          // i-type alu
    class_lui    = 3'd4,
    class_auipc  = 3'd5,
    class_jal    = 3'd6,
    class_jalr   = 3'd7
  } alu_class_e;

  typedef enum logic [3:0] {
    op_add,
    op_sub,
    op_sll,
    op_slt,
    op_sltu,
    op_xor,
    op_srl,
    op_sra,
    op_or,
    op_and,
    op_pass_b,                                    // lui
    op_link                                       // pc + 4 for jal/jalr
  } alu_op_e;

  // same values as branch funct3, 010 is free for br_none
  typedef enum logic [2:0] {
    br_eq   = 3'b000,
    br_ne   = 3'b001,
    br_none = 3'b010,
    br_lt   = 3'b100,
    br_ge   = 3'b101,
    br_ltu  = 3'b110,
    br_geu  = 3'b111
  } br_cond_e;

  typedef struct packed {
    logic                 valid;
    logic [xlen-1:0]      pc;
    logic [xlen-1:0]      rs1_val;
    logic [xlen-1:0]      rs2_val;
    logic [xlen-1:0]      imm;                    // already sign extended by id
    alu_class_e           alu_class;
    logic [2:0]           funct3;
    logic                 funct7_b5;
    logic [reg_idx_w-1:0] rd;
    logic                 reg_write;
    logic                 mem_read;
    logic                 mem_write;
    logic                 mem_to_reg;
  } ex_in_t;

  typedef struct packed {
    alu_op_e           alu_op;
    br_cond_e          br_cond;
    logic              use_imm;                   // operand b from imm
    logic              pc_base;                   // operand a from pc
    logic              is_jump;                   // jal or jalr
    logic              is_jalr;
    logic [mask_w-1:0] mem_mask;
  } ex_ctrl_t;

  typedef struct packed {
    logic                 valid;
    logic [xlen-1:0]      pc;
    logic [xlen-1:0]      alu_result;             // also the memory address
    logic [xlen-1:0]      store_data;
    logic [mask_w-1:0]    mem_mask;
    logic [reg_idx_w-1:0] rd;
    logic                 reg_write;
    logic                 mem_read;
    logic                 mem_write;
    logic                 mem_to_reg;
  } mem_out_t;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] target;
  } redirect_t;

endpackage

`default_nettype wire

/* ex_op_decode.sv */
// execute decode, turns alu class and funct bits into alu op, branch condition and lanes
`timescale 1ns/10ps
`default_nettype none

module ex_op_decode (
  input  rv_ex_pkg::ex_in_t   i_ex,
  output rv_ex_pkg::ex_ctrl_t o_ctrl
);

  logic [1:0]                   addr_lo;          // low address bits of rs1 + imm
  logic [rv_ex_pkg::mask_w-1:0] lanes;            // unshifted size pattern

  // funct3 to op, shared by r-type and i-type
  function automatic rv_ex_pkg::alu_op_e f3_op(input logic [2:0] f3, input logic alt,
                                               input logic sub_ok);
    rv_ex_pkg::alu_op_e op;
    case (f3)
      3'b000:  op = (alt && sub_ok) ? rv_ex_pkg::op_sub : rv_ex_pkg::op_add;
      3'b001:  op = rv_ex_pkg::op_sll;
      3'b010:  op = rv_ex_pkg::op_slt;
      3'b011:  op = rv_ex_pkg::op_sltu;
      3'b100:  op = rv_ex_pkg::op_xor;
      3'b101:  op = alt ? rv_ex_pkg::op_sra : rv_ex_pkg::op_srl;  // srai too
      3'b110:  op = rv_ex_pkg::op_or;
      default: op = rv_ex_pkg::op_and;
    endcase
    return op;
  endfunction

  always_comb
  begin
    addr_lo = i_ex.rs1_val[1:0] + i_ex.imm[1:0]; // wraps, only lane offset matters
    case (i_ex.funct3[1:0])                       // funct3[2] is signedness only
      rv_ex_pkg::sz_byte: lanes = rv_ex_pkg::lane_byte;
      rv_ex_pkg::sz_half: lanes = rv_ex_pkg::lane_half;
      rv_ex_pkg::sz_word: lanes = rv_ex_pkg::lane_word;
      default:            lanes = '0;             // no such access size
    endcase
  end

  always_comb
  begin
    o_ctrl.alu_op   = rv_ex_pkg::op_add;
    o_ctrl.br_cond  = rv_ex_pkg::br_none;
    o_ctrl.use_imm  = 1'b1;
    o_ctrl.pc_base  = 1'b0;
    o_ctrl.is_jump  = 1'b0;
    o_ctrl.is_jalr  = 1'b0;
    o_ctrl.mem_mask = '0;
    case (i_ex.alu_class)
      rv_ex_pkg::class_mem:
      begin
        o_ctrl.mem_mask = lanes << addr_lo;       // move lanes to addressed byte
      end
      rv_ex_pkg::class_branch:
      begin
        o_ctrl.alu_op  = rv_ex_pkg::op_sub;       // result unused, nothing written
        o_ctrl.use_imm = 1'b0;
        case (i_ex.funct3)
          3'b000:  o_ctrl.br_cond = rv_ex_pkg::br_eq;
          3'b001:  o_ctrl.br_cond = rv_ex_pkg::br_ne;
          3'b100:  o_ctrl.br_cond = rv_ex_pkg::br_lt;
          3'b101:  o_ctrl.br_cond = rv_ex_pkg::br_ge;
          3'b110:  o_ctrl.br_cond = rv_ex_pkg::br_ltu;
          3'b111:  o_ctrl.br_cond = rv_ex_pkg::br_geu;
          default: o_ctrl.br_cond = rv_ex_pkg::br_none;  // 010/011 never taken
        endcase
      end
      rv_ex_pkg::class_reg:
      begin
        o_ctrl.alu_op  = f3_op(i_ex.funct3, i_ex.funct7_b5, 1'b1);
        o_ctrl.use_imm = 1'b0;
      end
      rv_ex_pkg::class_imm:   o_ctrl.alu_op = f3_op(i_ex.funct3, i_ex.funct7_b5, 1'b0);
      rv_ex_pkg::class_lui:   o_ctrl.alu_op = rv_ex_pkg::op_pass_b;
      rv_ex_pkg::class_auipc: o_ctrl.pc_base = 1'b1;  // pc + imm
      rv_ex_pkg::class_jal:
      begin
        o_ctrl.alu_op  = rv_ex_pkg::op_link;
        o_ctrl.is_jump = 1'b1;
      end
      default:                                    // jalr
      begin
        o_ctrl.alu_op  = rv_ex_pkg::op_link;
        o_ctrl.is_jump = 1'b1;
        o_ctrl.is_jalr = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

/* alu_core.sv */
// rv32i integer alu, operand select plus all twelve execute operations
`timescale 1ns/10ps
`default_nettype none

module alu_core (
  input  rv_ex_pkg::ex_ctrl_t         i_ctrl,
  input  logic [rv_ex_pkg::xlen-1:0]  i_pc,
  input  logic [rv_ex_pkg::xlen-1:0]  i_rs1,
  input  logic [rv_ex_pkg::xlen-1:0]  i_rs2,
  input  logic [rv_ex_pkg::xlen-1:0]  i_imm,
  output logic [rv_ex_pkg::xlen-1:0]  o_result
);

  logic [rv_ex_pkg::xlen-1:0]    op_a;            // rs1 or pc
  logic [rv_ex_pkg::xlen-1:0]    op_b;            // rs2 or imm
  logic [rv_ex_pkg::shamt_w-1:0] shamt;           // low five bits only
  logic                          lt_s;
  logic                          lt_u;

  always_comb
  begin
    op_a  = i_ctrl.pc_base ? i_pc : i_rs1;        // auipc
    op_b  = i_ctrl.use_imm ? i_imm : i_rs2;
    shamt = op_b[rv_ex_pkg::shamt_w-1:0];
    lt_s  = $signed(op_a) < $signed(op_b);
    lt_u  = op_a < op_b;
  end

  always_comb
  begin
    o_result = '0;
    case (i_ctrl.alu_op)
      rv_ex_pkg::op_add:
      begin
        o_result = op_a + op_b;                   // also load/store address
      end
      rv_ex_pkg::op_sub:
      begin
        o_result = op_a - op_b;
      end
      rv_ex_pkg::op_sll:
      begin
        o_result = op_a << shamt;
      end
      rv_ex_pkg::op_slt:
      begin
        o_result[0] = lt_s;                       // upper bits stay zero
      end
      rv_ex_pkg::op_sltu:
      begin
        o_result[0] = lt_u;
      end
      rv_ex_pkg::op_xor:
      begin
        o_result = op_a ^ op_b;
      end
      rv_ex_pkg::op_srl:
      begin
        o_result = op_a >> shamt;                 // zero fill
      end
      rv_ex_pkg::op_sra:
      begin
        o_result = $unsigned($signed(op_a) >>> shamt);  // sign fill
      end
      rv_ex_pkg::op_or:
      begin
        o_result = op_a | op_b;
      end
      rv_ex_pkg::op_and:
      begin
        o_result = op_a & op_b;
      end
      rv_ex_pkg::op_pass_b:
      begin
        o_result = op_b;                          // lui, imm holds upper bits
      end
      rv_ex_pkg::op_link:
      begin
        o_result = i_pc + rv_ex_pkg::pc_step;     // return address
      end
      default:
      begin
        o_result = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* branch_resolve.sv */
// branch and jump resolution, condition compare and redirect target
`timescale 1ns/10ps
`default_nettype none

module branch_resolve (
  input  rv_ex_pkg::ex_ctrl_t         i_ctrl,
  input  logic [rv_ex_pkg::xlen-1:0]  i_pc,
  input  logic [rv_ex_pkg::xlen-1:0]  i_rs1,
  input  logic [rv_ex_pkg::xlen-1:0]  i_rs2,
  input  logic [rv_ex_pkg::xlen-1:0]  i_imm,
  output rv_ex_pkg::redirect_t        o_redirect
);

  logic                       eq;
  logic                       lt_s;
  logic                       lt_u;
  logic                       taken;              // conditional branch only
  logic [rv_ex_pkg::xlen-1:0] jalr_sum;

  always_comb
  begin
    eq   = i_rs1 == i_rs2;
    lt_s = $signed(i_rs1) < $signed(i_rs2);
    lt_u = i_rs1 < i_rs2;
    case (i_ctrl.br_cond)
      rv_ex_pkg::br_eq:  taken = eq;
      rv_ex_pkg::br_ne:  taken = !eq;
      rv_ex_pkg::br_lt:  taken = lt_s;
      rv_ex_pkg::br_ge:  taken = !lt_s;
      rv_ex_pkg::br_ltu: taken = lt_u;
      rv_ex_pkg::br_geu: taken = !lt_u;
      default:           taken = 1'b0;            // br_none, not a branch
    endcase
  end

  always_comb
  begin
    jalr_sum = i_rs1 + i_imm;
    o_redirect.valid = taken || i_ctrl.is_jump;   // bundle valid applied downstream
    if (i_ctrl.is_jalr)
    begin
      o_redirect.target = {jalr_sum[rv_ex_pkg::xlen-1:1], 1'b0};  // bit 0 dropped
    end
    else
    begin
      o_redirect.target = i_pc + i_imm;           // branches and jal
    end
  end

endmodule

`default_nettype wire

/* ex_mem_reg.sv */
// ex/mem pipeline register, holds on memory stall and sends a one cycle redirect
`timescale 1ns/10ps
`default_nettype none

module ex_mem_reg (
  input  logic                          i_clk,
  input  logic                          i_reset,
  input  rv_ex_pkg::ex_in_t             i_ex,
  input  logic [rv_ex_pkg::mask_w-1:0]  i_mask,
  input  logic [rv_ex_pkg::xlen-1:0]    i_result,
  input  rv_ex_pkg::redirect_t          i_redirect,
  input  logic                          i_mem_stall,
  output rv_ex_pkg::mem_out_t           o_mem,
  output rv_ex_pkg::redirect_t          o_redirect
);

  rv_ex_pkg::mem_out_t  mem_q;
  rv_ex_pkg::redirect_t redir_q;
  logic                 load;                     // take a new item this edge

  assign load = !i_mem_stall;

  always_ff @(posedge i_clk)
  begin
    if (i_reset)
    begin
      mem_q.valid      <= 1'b0;                   // control state only
      mem_q.reg_write  <= 1'b0;
      mem_q.mem_read   <= 1'b0;
      mem_q.mem_write  <= 1'b0;
      mem_q.mem_to_reg <= 1'b0;
      redir_q.valid    <= 1'b0;
    end
    else if (load)
    begin
      mem_q.valid      <= i_ex.valid;             // bubble when idle
      mem_q.reg_write  <= i_ex.valid && i_ex.reg_write;
      mem_q.mem_read   <= i_ex.valid && i_ex.mem_read;
      mem_q.mem_write  <= i_ex.valid && i_ex.mem_write;
      mem_q.mem_to_reg <= i_ex.valid && i_ex.mem_to_reg;
      mem_q.pc         <= i_ex.pc;
      mem_q.alu_result <= i_result;
      mem_q.store_data <= i_ex.rs2_val;           // store data is rs2 as is
      mem_q.mem_mask   <= i_mask;
      mem_q.rd         <= i_ex.rd;
      redir_q.valid    <= i_ex.valid && i_redirect.valid;
      redir_q.target   <= i_redirect.target;
    end
    else
    begin
      redir_q.valid    <= 1'b0;                   // no repeat while held
    end
  end

  assign o_mem      = mem_q;
  assign o_redirect = redir_q;

endmodule

`default_nettype wire

/* ex_stage.sv */
// rv32i execute stage top, decode, alu and branch logic feeding the ex/mem register
`timescale 1ns/10ps
`default_nettype none

module ex_stage (
  input  logic                    i_clk,
  input  logic                    i_reset,
  input  rv_ex_pkg::ex_in_t       i_ex,
  input  logic                    i_mem_stall,
  output rv_ex_pkg::mem_out_t     o_mem,
  output rv_ex_pkg::redirect_t    o_redirect,
  output logic                    o_ready
);

  rv_ex_pkg::ex_ctrl_t        ctrl;               // decoded op for this bundle
  logic [rv_ex_pkg::xlen-1:0] alu_result;
  rv_ex_pkg::redirect_t       br_redirect;        // not yet qualified by valid

  assign o_ready = !i_mem_stall;                  // one item per clock unless stalled

  ex_op_decode u_decode (
    .i_ex   (i_ex),
    .o_ctrl (ctrl)
  );

  alu_core u_alu (
    .i_ctrl   (ctrl),
    .i_pc     (i_ex.pc),
    .i_rs1    (i_ex.rs1_val),
    .i_rs2    (i_ex.rs2_val),
    .i_imm    (i_ex.imm),
    .o_result (alu_result)
  );

  branch_resolve u_branch (
    .i_ctrl     (ctrl),
    .i_pc       (i_ex.pc),
    .i_rs1      (i_ex.rs1_val),
    .i_rs2      (i_ex.rs2_val),
    .i_imm      (i_ex.imm),
    .o_redirect (br_redirect)
  );

  ex_mem_reg u_ex_mem (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_ex        (i_ex),
    .i_mask      (ctrl.mem_mask),
    .i_result    (alu_result),
    .i_redirect  (br_redirect),
    .i_mem_stall (i_mem_stall),
    .o_mem       (o_mem),
    .o_redirect  (o_redirect)
  );

endmodule

`default_nettype wire

/* tb_ex_model.svh */
// reference model for the execute stage results, byte lanes and redirects
`ifndef TB_EX_MODEL_SVH
`define TB_EX_MODEL_SVH

function automatic logic [31:0] expected_result(input rv_ex_pkg::ex_in_t b);
  logic [31:0] a;
  logic [31:0] y;
  logic [4:0]  sh;
  a  = b.rs1_val;
  y  = (b.alu_class == rv_ex_pkg::class_reg) ? b.rs2_val : b.imm;
  sh = y[4:0];                                    // upper operand bits ignored
  case (b.alu_class)
    rv_ex_pkg::class_lui:    return b.imm;
    rv_ex_pkg::class_auipc:  return b.pc + b.imm; // own pc of the instruction
    rv_ex_pkg::class_jal:    return b.pc + 32'd4;
    rv_ex_pkg::class_jalr:   return b.pc + 32'd4;
    rv_ex_pkg::class_mem:    return a + y;        // load/store address
    rv_ex_pkg::class_branch: return 32'd0;        // never compared
    default: ;
  endcase
  case (b.funct3)
    3'd0: return (b.alu_class == rv_ex_pkg::class_reg && b.funct7_b5) ? a - y : a + y;
    3'd1: return a << sh;
    3'd2: return {31'd0, (a ^ 32'h8000_0000) < (y ^ 32'h8000_0000)};  // biased for signed order
    3'd3: return {31'd0, a < y};
    3'd4: return a ^ y;
    3'd5: return b.funct7_b5 ? ((a >> sh) | (~(32'hffff_ffff >> sh) & {32{a[31]}})) : a >> sh;
    3'd6: return a | y;
    default: return a & y;
  endcase
endfunction

function automatic logic [3:0] lane_mask(input rv_ex_pkg::ex_in_t b);
  logic [31:0] addr;
  logic [3:0]  size_lanes;
  addr = b.rs1_val + b.imm;
  case (b.funct3[1:0])
    2'd0:    size_lanes = 4'b0001;               // byte
    2'd1:    size_lanes = 4'b0011;               // half
    2'd2:    size_lanes = 4'b1111;               // word
    default: size_lanes = 4'b0000;
  endcase
  if (b.alu_class != rv_ex_pkg::class_mem)
    return 4'b0000;
  return size_lanes << addr[1:0];
endfunction

function automatic logic takes_redirect(input rv_ex_pkg::ex_in_t b);
  logic signed [31:0] s1;
  logic signed [31:0] s2;
  s1 = b.rs1_val;
  s2 = b.rs2_val;
  if (b.alu_class == rv_ex_pkg::class_jal || b.alu_class == rv_ex_pkg::class_jalr)
    return 1'b1;
  if (b.alu_class != rv_ex_pkg::class_branch)
    return 1'b0;
  case (b.funct3)
    3'd0:    return b.rs1_val == b.rs2_val;
    3'd1:    return b.rs1_val != b.rs2_val;
    3'd4:    return s1 < s2;
    3'd5:    return s1 >= s2;
    3'd6:    return b.rs1_val < b.rs2_val;
    3'd7:    return b.rs1_val >= b.rs2_val;
    default: return 1'b0;                         // 010 and 011 are no branch
  endcase
endfunction

function automatic logic [31:0] redirect_target(input rv_ex_pkg::ex_in_t b);
  logic [31:0] sum;
  sum = b.rs1_val + b.imm;
  if (b.alu_class == rv_ex_pkg::class_jalr)
    return sum & 32'hffff_fffe;                  // bit 0 cleared
  return b.pc + b.imm;
endfunction

`endif

/* tb_ex_stage.sv */
// testbench for the rv32i execute stage with random bundles and a reference model
`timescale 1ns/10ps
`default_nettype none

module tb_ex_stage;

  localparam int period       = 100;
  localparam int reset_cycles = 16;
  localparam int n_alu        = 200;
  localparam int n_branch     = 150;
  localparam int n_jump       = 60;
  localparam int n_mem        = 150;
  localparam int n_stall      = 300;
  localparam int stall_limit  = 32;               // longest wait for one bundle
  localparam int margin       = 200;
  // up to four cycles per bundle once stalls and idle gaps are counted
  localparam int budget_cycles = reset_cycles + margin
                                 + 4 * (n_alu + n_branch + n_jump + n_mem + n_stall);

  typedef struct packed {
    rv_ex_pkg::mem_out_t mem;
    logic                check_result;            // branch results are not compared
  } expect_t;

  logic                 i_clk = 1'b0;
  logic                 i_reset;
  logic                 i_mem_stall;
  rv_ex_pkg::ex_in_t    i_ex;
  rv_ex_pkg::mem_out_t  o_mem;
  rv_ex_pkg::redirect_t o_redirect;
  logic                 o_ready;

  expect_t              exp_q[$];                 // bundle held in ex/mem
  logic                 exp_redirect = 1'b0;
  logic [31:0]          exp_target;
  logic                 started = 1'b0;
  logic                 stall_mode = 1'b0;
  logic [31:0]          lfsr = 32'h56f0;
  string                cur_test;
  int                   test_errors = 0;
  int                   accepted = 0;
  int                   tests_run = 0;
  int                   tests_failed = 0;
  int                   total_errors = 0;

  ex_stage DUT (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_ex        (i_ex),
    .i_mem_stall (i_mem_stall),
    .o_mem       (o_mem),
    .o_redirect  (o_redirect),
    .o_ready     (o_ready)
  );

  `include "tb_ex_model.svh"

  always #(period / 2) i_clk = ~i_clk;

  function automatic logic next_bit();
    lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};  // x^32+x^22+x^2+x+1
    return lfsr[0];
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[30:0], next_bit()};
    return v;
  endfunction

  function automatic logic [31:0] rand_imm(input int width);
    logic [31:0] v;
    v = take_bits(width);
    if (v[width-1])
      v = v | (32'hffff_ffff << width);           // sign extend
    return v;
  endfunction

  function automatic rv_ex_pkg::ex_in_t make_bundle(input rv_ex_pkg::alu_class_e cls);
    rv_ex_pkg::ex_in_t b;
    b           = '0;
    b.valid     = 1'b1;
    b.alu_class = cls;
    b.pc        = take_bits(32) & 32'hffff_fffc;
    b.rs1_val   = take_bits(32);
    b.rs2_val   = take_bits(32);
    b.imm       = rand_imm(12);
    b.funct3    = 3'(take_bits(3));
    b.funct7_b5 = next_bit();
    b.rd        = 5'(take_bits(5));
    case (cls)
      rv_ex_pkg::class_branch:
      begin
        b.imm = rand_imm(13) & 32'hffff_fffe;
        if (next_bit())
          b.rs2_val = next_bit() ? b.rs1_val : b.rs1_val ^ 32'h8000_0000;  // equal or sign apart
      end
      rv_ex_pkg::class_lui:   b.imm = take_bits(20) << 12;
      rv_ex_pkg::class_auipc: b.imm = take_bits(20) << 12;
      rv_ex_pkg::class_jal:   b.imm = rand_imm(21) & 32'hffff_fffe;
      rv_ex_pkg::class_mem:
      begin
        b.mem_write = next_bit();
        if (b.funct3[1:0] == 2'b11)
          b.funct3[1:0] = 2'b10;
        if (b.mem_write || b.funct3[1:0] == 2'b10)
          b.funct3[2] = 1'b0;                     // only lb/lh have an unsigned form
      end
      default: ;
    endcase
    b.reg_write  = cls != rv_ex_pkg::class_branch && !b.mem_write;
    b.mem_read   = cls == rv_ex_pkg::class_mem && !b.mem_write;
    b.mem_to_reg = b.mem_read;
    return b;
  endfunction

  function automatic expect_t expect_entry(input rv_ex_pkg::ex_in_t b);
    expect_t e;
    e.mem.valid      = 1'b1;
    e.mem.pc         = b.pc;
    e.mem.alu_result = expected_result(b);
    e.mem.store_data = b.rs2_val;
    e.mem.mem_mask   = lane_mask(b);
    e.mem.rd         = b.rd;
    e.mem.reg_write  = b.reg_write;
    e.mem.mem_read   = b.mem_read;
    e.mem.mem_write  = b.mem_write;
    e.mem.mem_to_reg = b.mem_to_reg;
    e.check_result   = b.alu_class != rv_ex_pkg::class_branch;
    return e;
  endfunction

  task automatic check_field(input string field, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    assert (act_v === exp_v)
    else
    begin
      $display("mismatch %s %s expected %h actual %h", cur_test, field, exp_v, act_v);
      test_errors++;
    end
  endtask

  // what the ex/mem register must hold after each edge
  always @(posedge i_clk)
  begin
    started      = 1'b1;
    exp_redirect = 1'b0;                          // one cycle only, none while held
    if (i_reset)
      exp_q.delete();
    else if (!i_mem_stall)
    begin
      if (exp_q.size() != 0)
        void'(exp_q.pop_front());
      if (i_ex.valid)
      begin
        exp_q.push_back(expect_entry(i_ex));
        exp_redirect = takes_redirect(i_ex);
        exp_target   = redirect_target(i_ex);
        accepted++;
      end
    end
  end

  always @(negedge i_clk)
  begin
    expect_t e;
    e = '0;                                       // bubble unless a bundle is held
    if (exp_q.size() != 0)
      e = exp_q[0];
    if (started)
    begin
      assert (o_ready === !i_mem_stall)
      else
      begin
        $display("error in %s, o_ready does not follow the memory stall", cur_test);
        test_errors++;
      end
      check_field("redirect valid", 32'(exp_redirect), 32'(o_redirect.valid));
      if (exp_redirect)
        check_field("redirect target", exp_target, o_redirect.target);
      check_field("valid", 32'(e.mem.valid), 32'(o_mem.valid));
      check_field("reg_write", 32'(e.mem.reg_write), 32'(o_mem.reg_write));
      check_field("mem_read", 32'(e.mem.mem_read), 32'(o_mem.mem_read));
      check_field("mem_write", 32'(e.mem.mem_write), 32'(o_mem.mem_write));
      check_field("mem_to_reg", 32'(e.mem.mem_to_reg), 32'(o_mem.mem_to_reg));
      if (e.mem.valid)
      begin
        check_field("pc", e.mem.pc, o_mem.pc);
        if (e.check_result)
          check_field("alu_result", e.mem.alu_result, o_mem.alu_result);
        check_field("store_data", e.mem.store_data, o_mem.store_data);
        check_field("mem_mask", 32'(e.mem.mem_mask), 32'(o_mem.mem_mask));
        check_field("rd", 32'(e.mem.rd), 32'(o_mem.rd));
      end
    end
  end

  task automatic send(input rv_ex_pkg::ex_in_t b);
    int waited;
    waited = 0;
    i_ex        <= b;
    i_mem_stall <= stall_mode && next_bit();
    @(posedge i_clk);
    while (!o_ready)                              // hold the bundle until taken
    begin
      waited++;
      if (waited > stall_limit)
      begin
        $display("error in %s, bundle not accepted after %0d stalled cycles", cur_test, waited);
        test_errors++;
        return;
      end
      i_mem_stall <= stall_mode && next_bit();
      @(posedge i_clk);
    end
  endtask

  task automatic send_op(input rv_ex_pkg::alu_class_e cls, input logic [2:0] f3,
                         input logic f7, input logic [31:0] rs1, input logic [31:0] rs2,
                         input logic [31:0] imm);
    rv_ex_pkg::ex_in_t b;
    b           = make_bundle(cls);
    b.funct3    = f3;
    b.funct7_b5 = f7;
    b.rs1_val   = rs1;
    b.rs2_val   = rs2;
    b.imm       = imm;
    send(b);
  endtask

  task automatic idle(input int n);
    rv_ex_pkg::ex_in_t b;
    repeat (n)
    begin
      b            = make_bundle(rv_ex_pkg::class_reg);
      b.valid      = 1'b0;                        // stray enables must not pass
      b.mem_read   = next_bit();
      b.mem_write  = next_bit();
      b.mem_to_reg = next_bit();
      i_ex        <= b;
      i_mem_stall <= stall_mode && next_bit();
      @(posedge i_clk);
    end
  endtask

  task automatic begin_test(input string name);
    cur_test    = name;
    test_errors = 0;
    accepted    = 0;
  endtask

  task automatic end_test();
    stall_mode = 1'b0;
    idle(2);                                      // last bundle seen, then a bubble
    tests_run++;
    total_errors += test_errors;
    if (test_errors == 0)
      $display("test %s ok, %0d bundles", cur_test, accepted);
    else
    begin
      tests_failed++;
      $display("test %s failed, %0d errors in %0d bundles", cur_test, test_errors, accepted);
    end
  endtask

  initial
  begin
    i_reset     = 1'b1;
    i_mem_stall = 1'b0;
    i_ex        = make_bundle(rv_ex_pkg::class_jal);  // valid jump that reset must block
    begin_test("reset");
    repeat (reset_cycles) @(posedge i_clk);
    i_reset <= 1'b0;
    send_op(rv_ex_pkg::class_imm, 3'd0, 1'b0, 32'd5, 32'd0, 32'd7);  // first addi
    end_test();

    begin_test("alu_ops");
    send_op(rv_ex_pkg::class_reg, 3'd5, 1'b1, 32'h8000_0010, 32'hffff_ffe4, 32'd0);  // sra
    send_op(rv_ex_pkg::class_imm, 3'd5, 1'b1, 32'hf000_0000, 32'd0, 32'h0000_0408);  // srai
    send_op(rv_ex_pkg::class_reg, 3'd2, 1'b0, 32'hffff_ffff, 32'd1, 32'd0);  // slt true
    send_op(rv_ex_pkg::class_reg, 3'd3, 1'b0, 32'hffff_ffff, 32'd1, 32'd0);  // sltu false
    send_op(rv_ex_pkg::class_reg, 3'd0, 1'b1, 32'd3, 32'd10, 32'd0);         // negative sub
    repeat (n_alu)
      send(make_bundle(rv_ex_pkg::alu_class_e'(3'd2 + 3'(take_bits(2)))));  // reg to auipc
    end_test();

    begin_test("branches");
    repeat (n_branch)
      send(make_bundle(rv_ex_pkg::class_branch));
    end_test();

    begin_test("jumps");
    repeat (n_jump)
      send(make_bundle(next_bit() ? rv_ex_pkg::class_jal : rv_ex_pkg::class_jalr));
    end_test();

    begin_test("load_store");
    repeat (n_mem)
      send(make_bundle(rv_ex_pkg::class_mem));
    end_test();

    begin_test("stall");
    stall_mode = 1'b1;
    repeat (n_stall)
    begin
      send(make_bundle(rv_ex_pkg::alu_class_e'(3'(take_bits(3)))));
      if (take_bits(2) == 32'd0)
        idle(1 + int'(take_bits(2)));
    end
    end_test();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
    if (tests_failed == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

  initial
  begin
    #(budget_cycles * period);
    $display("error: watchdog expired during test %s", cur_test);
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
rv_ex_pkg.sv
ex_op_decode.sv
alu_core.sv
branch_resolve.sv
ex_mem_reg.sv
ex_stage.sv
tb_ex_stage.sv

/* Makefile */
# verilator build for the rv32i execute stage testbench
TOP := tb_ex_stage

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
